//--- include/scene_config.svh
`ifndef SCENE_CONFIG_SVH
`define SCENE_CONFIG_SVH

// frame geometry in pixels
`define FRAME_WIDTH 16
`define FRAME_HEIGHT 12

// entries in the shape table
`define NUM_SHAPES 4

`define COORD_BITS 4   // one screen coordinate
`define COLOR_BITS 12  // 4 bits each of r, g, b

// frame buffer is 256 deep, one frame uses 192 words
`define FB_ADDR_BITS 8

`endif

//--- src/scene_pkg.sv
`default_nettype none
`include "scene_config.svh"

package scene_pkg;

  // host opcodes, anything not listed is illegal
  typedef enum logic [3:0] {
    OP_NOP         = 4'd0,
    OP_SET_BG      = 4'd1,
    OP_SET_SHAPE   = 4'd2,
    OP_CLEAR_SHAPE = 4'd3,
    OP_RENDER      = 4'd4
  } scene_op_e;

  // 40 bit word as sent by the host
  typedef struct packed {
    logic [3:0]             opcode;  // raw code, may be illegal
    logic [1:0]             shape_idx;
    logic [`COORD_BITS-1:0] x0;
    logic [`COORD_BITS-1:0] y0;
    logic [`COORD_BITS-1:0] x1;
    logic [`COORD_BITS-1:0] y1;
    logic [`COLOR_BITS-1:0] color;
    logic [5:0]             pad;
  } scene_inst_t;

  // one rectangle, bounds are inclusive
  typedef struct packed {
    logic                   en;
    logic [`COORD_BITS-1:0] x0;
    logic [`COORD_BITS-1:0] y0;
    logic [`COORD_BITS-1:0] x1;
    logic [`COORD_BITS-1:0] y1;
    logic [`COLOR_BITS-1:0] color;
  } shape_t;

  typedef struct packed {
    scene_op_e  op;
    logic [1:0] idx;
    shape_t     shape;
  } decoded_inst_t;

  typedef struct packed {
    logic [`COORD_BITS-1:0] x;
    logic [`COORD_BITS-1:0] y;
    logic [`COLOR_BITS-1:0] color;
  } pixel_t;

  typedef enum logic [1:0] {
    RS_IDLE,
    RS_TEST,  // one shape per cycle
    RS_EMIT
  } ray_state_e;

endpackage

`default_nettype wire

//--- src/inst_decoder.sv
`default_nettype none
`include "scene_config.svh"

module inst_decoder import scene_pkg::*; (
  input  wire           sys_clk,
  input  wire           sys_rst,
  input  wire           inst_valid,
  input  wire  scene_inst_t inst,
  output logic          dec_valid,
  output decoded_inst_t dec_inst,
  output logic          inst_error
);

  logic op_legal;
  logic op_nop;

  always_comb begin
    case (inst.opcode)
      OP_NOP, OP_SET_BG, OP_SET_SHAPE, OP_CLEAR_SHAPE, OP_RENDER: op_legal = 1'b1;
      default: op_legal = 1'b0;
    endcase
  end

  assign op_nop = inst.opcode == OP_NOP;

  // strobes, nop is legal but produces nothing downstream
  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      dec_valid  <= 1'b0;
      inst_error <= 1'b0;
    end else begin
      dec_valid  <= inst_valid && op_legal && !op_nop;
      inst_error <= inst_valid && !op_legal;
    end
  end

  // field split, only meaningful when dec_valid is high
  always_ff @(posedge sys_clk) begin
    if (inst_valid) begin
      dec_inst.op          <= scene_op_e'(inst.opcode);
      dec_inst.idx         <= inst.shape_idx;
      dec_inst.shape.en    <= inst.opcode == OP_SET_SHAPE;  // clear writes a disabled entry
      dec_inst.shape.x0    <= inst.x0;
      dec_inst.shape.y0    <= inst.y0;
      dec_inst.shape.x1    <= inst.x1;
      dec_inst.shape.y1    <= inst.y1;
      dec_inst.shape.color <= inst.color;
    end
  end

  a_valid_or_error: assert property (@(posedge sys_clk) disable iff (sys_rst)
    !(dec_valid && inst_error));

endmodule

`default_nettype wire

//--- src/scene_executor.sv
`default_nettype none
`include "scene_config.svh"

module scene_executor import scene_pkg::*; (
  input  wire                           sys_clk,
  input  wire                           sys_rst,
  input  wire                           dec_valid,
  input  wire  decoded_inst_t           dec_inst,
  input  wire                           frame_done,
  output shape_t [`NUM_SHAPES-1:0]      shapes,
  output logic [`COLOR_BITS-1:0]        bg_color,
  output logic                          render_start,
  output logic                          busy
);

  // table and background start cleared so an empty scene renders black
  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      shapes       <= '0;
      bg_color     <= '0;
      render_start <= 1'b0;
      busy         <= 1'b0;
    end else begin
      render_start <= 1'b0;
      if (frame_done) begin
        busy <= 1'b0;  // falls the cycle after the last write
      end
      if (dec_valid) begin
        case (dec_inst.op)
          OP_SET_BG: bg_color <= dec_inst.shape.color;
          OP_SET_SHAPE, OP_CLEAR_SHAPE: shapes[dec_inst.idx] <= dec_inst.shape;
          OP_RENDER: begin
            render_start <= 1'b1;
            busy         <= 1'b1;
          end
          default: ;
        endcase
      end
    end
  end

  // host must wait for busy to drop before sending more work
  a_no_inst_while_busy: assert property (@(posedge sys_clk) disable iff (sys_rst)
    !(dec_valid && busy));

  // the writer only finishes frames this stage started
  a_done_only_when_busy: assert property (@(posedge sys_clk) disable iff (sys_rst)
    frame_done |-> busy);

endmodule

`default_nettype wire

//--- src/ray_controller.sv
`default_nettype none
`include "scene_config.svh"

module ray_controller import scene_pkg::*; (
  input  wire                           sys_clk,
  input  wire                           sys_rst,
  input  wire                           render_start,
  input  wire  shape_t [`NUM_SHAPES-1:0] shapes,
  input  wire  [`COLOR_BITS-1:0]        bg_color,
  output logic                          pix_valid,
  output pixel_t                        pix
);

  localparam int unsigned SHAPE_BITS = $clog2(`NUM_SHAPES);

  ray_state_e             state;
  logic [`COORD_BITS-1:0] x_cnt;
  logic [`COORD_BITS-1:0] y_cnt;
  logic [SHAPE_BITS-1:0]  shape_cnt;
  logic                   hit;    // an earlier shape already owns this pixel
  logic [`COLOR_BITS-1:0] color;
  shape_t                 cur;
  logic                   covers;
  logic                   last_shape;
  logic                   last_x;
  logic                   last_y;

  assign cur    = shapes[shape_cnt];
  assign covers = cur.en && (x_cnt >= cur.x0) && (x_cnt <= cur.x1)
                  && (y_cnt >= cur.y0) && (y_cnt <= cur.y1);

  assign last_shape = shape_cnt == SHAPE_BITS'(`NUM_SHAPES - 1);
  assign last_x     = x_cnt == `COORD_BITS'(`FRAME_WIDTH - 1);
  assign last_y     = y_cnt == `COORD_BITS'(`FRAME_HEIGHT - 1);

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      state     <= RS_IDLE;
      x_cnt     <= '0;
      y_cnt     <= '0;
      shape_cnt <= '0;
      hit       <= 1'b0;
    end else begin
      case (state)
        RS_IDLE: begin
          if (render_start) begin
            state     <= RS_TEST;
            x_cnt     <= '0;
            y_cnt     <= '0;
            shape_cnt <= '0;
            hit       <= 1'b0;
          end
        end
        RS_TEST: begin
          shape_cnt <= shape_cnt + 1'b1;
          if (covers) hit <= 1'b1;
          if (last_shape) state <= RS_EMIT;
        end
        RS_EMIT: begin
          shape_cnt <= '0;
          hit       <= 1'b0;
          if (last_x) begin
            x_cnt <= '0;
            y_cnt <= y_cnt + 1'b1;
          end else begin
            x_cnt <= x_cnt + 1'b1;
          end
          state <= (last_x && last_y) ? RS_IDLE : RS_TEST;  // frame complete
        end
        default: state <= RS_IDLE;
      endcase
    end
  end

  // lowest index wins, shape 0 also loads the background on a miss
  always_ff @(posedge sys_clk) begin
    if (state == RS_TEST) begin
      if (shape_cnt == '0) begin
        color <= covers ? cur.color : bg_color;
      end else if (covers && !hit) begin
        color <= cur.color;
      end
    end
  end

  assign pix_valid = state == RS_EMIT;
  assign pix       = '{x: x_cnt, y: y_cnt, color: color};

  a_start_when_idle: assert property (@(posedge sys_clk) disable iff (sys_rst)
    render_start |-> state == RS_IDLE);

endmodule

`default_nettype wire

//--- src/pixel_writer.sv
`default_nettype none
`include "scene_config.svh"

module pixel_writer import scene_pkg::*; (
  input  wire                       sys_clk,
  input  wire                       sys_rst,
  input  wire                       pix_valid,
  input  wire  pixel_t              pix,
  input  wire  [`FB_ADDR_BITS-1:0]  rd_addr,
  output logic [`COLOR_BITS-1:0]    rd_data,
  output logic                      frame_done
);

  localparam int unsigned FRAME_PIXELS = `FRAME_WIDTH * `FRAME_HEIGHT;

  logic [`COLOR_BITS-1:0]   fb [2**`FB_ADDR_BITS];
  logic [`FB_ADDR_BITS-1:0] wr_addr;
  logic [`FB_ADDR_BITS-1:0] wr_count;  // pixels written this frame
  logic                     last_pix;

  assign wr_addr  = `FB_ADDR_BITS'(pix.y * `FRAME_WIDTH + pix.x);
  assign last_pix = wr_count == `FB_ADDR_BITS'(FRAME_PIXELS - 1);

  always_ff @(posedge sys_clk) begin
    if (pix_valid) begin
      fb[wr_addr] <= pix.color;
    end
    rd_data <= fb[rd_addr];  // one cycle read latency
  end

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      wr_count   <= '0;
      frame_done <= 1'b0;
    end else begin
      frame_done <= pix_valid && last_pix;
      if (pix_valid) begin
        wr_count <= last_pix ? '0 : wr_count + 1'b1;
      end
    end
  end

  // controller walks in raster order, so the address tracks the count
  a_raster_order: assert property (@(posedge sys_clk) disable iff (sys_rst)
    pix_valid |-> wr_addr == wr_count);

endmodule

`default_nettype wire

//--- src/raster_top.sv
`default_nettype none
`include "scene_config.svh"

module raster_top import scene_pkg::*; (
  input  wire                       sys_clk,
  input  wire                       sys_rst,
  input  wire                       inst_valid,
  input  wire  scene_inst_t         inst,
  input  wire  [`FB_ADDR_BITS-1:0]  rd_addr,
  output logic                      busy,
  output logic                      inst_error,
  output logic                      pix_valid,
  output pixel_t                    pix,
  output logic                      frame_done,
  output logic [`COLOR_BITS-1:0]    rd_data
);

  logic                         dec_valid;
  decoded_inst_t                dec_inst;
  shape_t [`NUM_SHAPES-1:0]     shapes;
  logic [`COLOR_BITS-1:0]       bg_color;
  logic                         render_start;

  inst_decoder u_decoder (
    .sys_clk    (sys_clk),
    .sys_rst    (sys_rst),
    .inst_valid (inst_valid),
    .inst       (inst),
    .dec_valid  (dec_valid),
    .dec_inst   (dec_inst),
    .inst_error (inst_error)
  );

  scene_executor u_executor (
    .sys_clk      (sys_clk),
    .sys_rst      (sys_rst),
    .dec_valid    (dec_valid),
    .dec_inst     (dec_inst),
    .frame_done   (frame_done),
    .shapes       (shapes),
    .bg_color     (bg_color),
    .render_start (render_start),
    .busy         (busy)
  );

  ray_controller u_ray (
    .sys_clk      (sys_clk),
    .sys_rst      (sys_rst),
    .render_start (render_start),
    .shapes       (shapes),
    .bg_color     (bg_color),
    .pix_valid    (pix_valid),
    .pix          (pix)
  );

  // result stage, also closes the busy loop through frame_done
  pixel_writer u_writer (
    .sys_clk    (sys_clk),
    .sys_rst    (sys_rst),
    .pix_valid  (pix_valid),
    .pix        (pix),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .frame_done (frame_done)
  );

endmodule

`default_nettype wire

//--- verif/tb_raster_top.sv
`default_nettype none
`include "scene_config.svh"

module tb_raster_top import scene_pkg::*;;

  localparam int FRAME_PIXELS = `FRAME_WIDTH * `FRAME_HEIGHT;
  localparam int FRAME_CYCLES = FRAME_PIXELS * (`NUM_SHAPES + 1);
  localparam int MAX_CYCLES   = 2 * (10 * FRAME_CYCLES) + 800;  // ten frames with double margin

  logic                     sys_clk;
  logic                     sys_rst;
  logic                     inst_valid;
  scene_inst_t              inst;
  logic [`FB_ADDR_BITS-1:0] rd_addr;
  logic                     busy;
  logic                     inst_error;
  logic                     pix_valid;
  pixel_t                   pix;
  logic                     frame_done;
  logic [`COLOR_BITS-1:0]   rd_data;

  // reference model state
  shape_t                 m_shapes [`NUM_SHAPES];
  logic [`COLOR_BITS-1:0] m_bg;
  logic [`COLOR_BITS-1:0] exp_fb [FRAME_PIXELS];  // expected colours of the last frame

  int errors;
  int test_errors;
  int tests_run;
  int cycles = 0;
  int done_pulses = 0;

  raster_top dut (
    .sys_clk    (sys_clk),
    .sys_rst    (sys_rst),
    .inst_valid (inst_valid),
    .inst       (inst),
    .rd_addr    (rd_addr),
    .busy       (busy),
    .inst_error (inst_error),
    .pix_valid  (pix_valid),
    .pix        (pix),
    .frame_done (frame_done),
    .rd_data    (rd_data)
  );

  initial begin
    sys_clk = 1'b0;
    forever #2 sys_clk = ~sys_clk;
  end

  always @(posedge sys_clk) begin
    cycles <= cycles + 1;
    if (frame_done) done_pulses <= done_pulses + 1;
    if (cycles == MAX_CYCLES) begin
      $display("timeout: run stopped after %0d cycles", cycles);
      $display("TB FAILED");
      $finish;
    end
  end

  // lowest enabled index that covers the pixel wins
  function automatic logic [`COLOR_BITS-1:0] model_color(input logic [`COORD_BITS-1:0] x,
                                                         input logic [`COORD_BITS-1:0] y);
    logic [`COLOR_BITS-1:0] c;
    c = m_bg;
    for (int i = `NUM_SHAPES - 1; i >= 0; i--) begin
      if (m_shapes[i].en && x >= m_shapes[i].x0 && x <= m_shapes[i].x1
          && y >= m_shapes[i].y0 && y <= m_shapes[i].y1) c = m_shapes[i].color;
    end
    return c;
  endfunction

  function automatic shape_t random_shape();
    shape_t s;
    s.en    = 1'b1;
    s.x0    = `COORD_BITS'($urandom_range(`FRAME_WIDTH - 1, 0));  // x0 > x1 gives an empty shape
    s.x1    = `COORD_BITS'($urandom_range(`FRAME_WIDTH - 1, 0));
    s.y0    = `COORD_BITS'($urandom_range(`FRAME_HEIGHT - 1, 0));
    s.y1    = `COORD_BITS'($urandom_range(`FRAME_HEIGHT - 1, 0));
    s.color = `COLOR_BITS'($urandom);
    return s;
  endfunction

  // one-cycle strobe with inst_error checked right after the capturing edge
  task automatic send(input logic [3:0] op, input logic [1:0] idx, input shape_t s);
    logic expect_err;
    expect_err = !(op inside {OP_NOP, OP_SET_BG, OP_SET_SHAPE, OP_CLEAR_SHAPE, OP_RENDER});
    inst = '{opcode: op, shape_idx: idx, x0: s.x0, y0: s.y0, x1: s.x1, y1: s.y1,
             color: s.color, pad: 6'd0};
    inst_valid = 1'b1;
    @(posedge sys_clk);
    #1;
    inst_valid = 1'b0;
    if (inst_error !== expect_err) begin
      $display("MISMATCH @%0t: inst_error %b for opcode %0d", $time, inst_error, op);
      errors++;
    end
  endtask

  task automatic set_bg(input logic [`COLOR_BITS-1:0] color);
    shape_t s;
    s = '0;
    s.color = color;
    send(OP_SET_BG, 2'd0, s);
    m_bg = color;
  endtask

  task automatic set_shape(input logic [1:0] idx, input shape_t s);
    send(OP_SET_SHAPE, idx, s);
    m_shapes[idx] = s;
  endtask

  task automatic clear_shape(input logic [1:0] idx);
    send(OP_CLEAR_SHAPE, idx, random_shape());
    m_shapes[idx].en = 1'b0;
  endtask

  // render one frame and check every pixel in raster order
  task automatic render_frame();
    logic [`COORD_BITS-1:0] ex;
    logic [`COORD_BITS-1:0] ey;
    logic [`COLOR_BITS-1:0] ec;
    int start_pulses;
    start_pulses = done_pulses;
    send(OP_RENDER, 2'd0, '0);
    for (int n = 0; n < FRAME_PIXELS; n++) begin
      ex = `COORD_BITS'(n % `FRAME_WIDTH);
      ey = `COORD_BITS'(n / `FRAME_WIDTH);
      ec = model_color(ex, ey);
      exp_fb[n] = ec;
      while (pix_valid !== 1'b1) begin
        if (frame_done === 1'b1) begin
          $display("frame_done pulsed early, after %0d pixels", n);
          errors++;
        end
        @(posedge sys_clk);
        #1;
      end
      if (busy !== 1'b1) begin
        $display("busy was low while pixel %0d was emitted", n);
        errors++;
      end
      if (pix.x !== ex || pix.y !== ey) begin
        $display("MISMATCH @%0t: pixel at (%0d,%0d), expected (%0d,%0d)",
                 $time, pix.x, pix.y, ex, ey);
        errors++;
      end
      if (pix.color !== ec) begin
        $display("MISMATCH @%0t: colour %h at (%0d,%0d), expected %h",
                 $time, pix.color, ex, ey, ec);
        errors++;
      end
      @(posedge sys_clk);
      #1;
    end
    if (frame_done !== 1'b1 || pix_valid !== 1'b0) begin
      $display("frame_done did not follow the last pixel alone");
      errors++;
    end
    @(posedge sys_clk);
    #1;
    if (busy !== 1'b0 || frame_done !== 1'b0 || pix_valid !== 1'b0) begin
      $display("busy did not fall, or output kept going, after frame_done");
      errors++;
    end
    if (done_pulses != start_pulses + 1) begin
      $display("frame_done pulsed %0d times in one frame", done_pulses - start_pulses);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == test_errors) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, errors - test_errors);
    test_errors = errors;
  endtask

  initial begin
    logic [1:0] clear_idx;
    shape_t     full;
    void'($urandom(32'h76a8_bb05));
    errors      = 0;
    test_errors = 0;
    tests_run   = 0;
    sys_rst     = 1'b1;
    inst_valid  = 1'b0;
    inst        = '0;
    rd_addr     = '0;
    m_bg        = '0;
    for (int i = 0; i < `NUM_SHAPES; i++) m_shapes[i] = '0;
    repeat (16) @(posedge sys_clk);
    #1;
    sys_rst = 1'b0;

    if (busy !== 1'b0 || pix_valid !== 1'b0 || frame_done !== 1'b0 || inst_error !== 1'b0) begin
      $display("outputs were not idle after reset");
      errors++;
    end
    render_frame();  // empty table gives background only
    end_test("reset_state");

    for (int f = 0; f < 6; f++) begin
      set_bg(`COLOR_BITS'($urandom));
      repeat ($urandom_range(4, 1)) set_shape(2'($urandom_range(3, 0)), random_shape());
      render_frame();
    end
    end_test("random_scenes");

    render_frame();  // same scene again for order and frame_done per pixel
    end_test("raster_order");

    clear_idx  = 2'($urandom_range(3, 0));
    full       = '0;
    full.en    = 1'b1;
    full.x1    = `COORD_BITS'(`FRAME_WIDTH - 1);
    full.y1    = `COORD_BITS'(`FRAME_HEIGHT - 1);
    full.color = `COLOR_BITS'($urandom);
    set_shape(clear_idx, full);  // whole frame so a missed clear shows up
    clear_shape(clear_idx);
    render_frame();
    end_test("clear_shape");

    repeat (3) send(4'($urandom_range(15, 5)), 2'($urandom_range(3, 0)), random_shape());
    render_frame();
    end_test("illegal_opcodes");

    for (int a = 0; a < FRAME_PIXELS; a++) begin
      rd_addr = `FB_ADDR_BITS'(a);
      @(posedge sys_clk);
      #1;
      if (rd_data !== exp_fb[a]) begin
        $display("MISMATCH @%0t: rd_data %h at address %0d, expected %h",
                 $time, rd_data, a, exp_fb[a]);
        errors++;
      end
    end
    end_test("readback");

    $display("tests %0d, errors %0d, cycles %0d", tests_run, errors, cycles);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+include
src/scene_pkg.sv
src/inst_decoder.sv
src/scene_executor.sv
src/ray_controller.sv
src/pixel_writer.sv
src/raster_top.sv
verif/tb_raster_top.sv

//--- run_sim.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_raster_top -o sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "TB PASSED"; then
  exit 0
fi
exit 1
